//--- list.f
hw/div_pkg.sv
hw/div_issue.sv
hw/div_core.sv
hw/div_writeback.sv
hw/div_unit_top.sv
testbench/div_unit_checker.sv
testbench/div_unit_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module div_unit_tb -f list.f -o div_sim

status=0
./obj_dir/div_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    exit "$status"
fi
echo "simulation passed"

//--- testbench/div_input.txt
// op(0 DIV, 1 DIVU, 2 REM, 3 REMU) dividend divisor waddr commit_id int expected
// first four lines carry no interrupt and distinct commit ids
0 00000014 00000003 01 0 0 00000006
1 FFFFFFFF 00000002 02 1 0 7FFFFFFF
2 FFFFFFEC 00000003 03 2 0 FFFFFFFE
3 00000064 00000007 04 3 0 00000002
0 FFFFFFEC 00000003 05 4 0 FFFFFFFA
0 00000014 FFFFFFFD 06 5 0 FFFFFFFA
0 FFFFFFEC FFFFFFFD 07 6 0 00000006
2 00000014 FFFFFFFD 08 7 0 00000002
0 12345678 00000000 09 0 0 FFFFFFFF
2 12345678 00000000 0A 1 0 12345678
1 80000000 00000000 0B 2 0 FFFFFFFF
3 80000000 00000000 0C 3 0 80000000
0 80000000 FFFFFFFF 0D 4 0 80000000
2 80000000 FFFFFFFF 0E 5 0 00000000
0 00000064 00000005 0F 6 1 00000014
1 80000000 FFFFFFFF 10 7 0 00000000
3 80000000 FFFFFFFF 11 0 0 80000000
0 7FFFFFFF 00000001 12 1 0 7FFFFFFF
2 FFFFFF9C 00000007 13 2 0 FFFFFFFE
1 DEADBEEF 00001000 14 3 0 000DEADB
3 DEADBEEF 00001000 15 4 0 00000EEF
2 00000007 00000002 16 5 1 00000001
0 00000000 00000005 17 6 0 00000000
0 80000000 00000002 18 7 0 C0000000

//--- testbench/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb
    import div_pkg::*;
();

    localparam int RST_CYCLES  = 10;
    localparam int BP_COUNT    = 4;
    localparam int HOLD_CYCLES = 3 * XLEN;
    localparam int VEC_CYCLES  = XLEN + 10;
    localparam int STALL_LIMIT = HOLD_CYCLES + 2 * VEC_CYCLES;
    localparam int MAX_VEC     = 32;

    logic            clk;
    logic            rst_n;
    logic            req_i;
    div_op_e         op_i;
    logic [XLEN-1:0] dividend_i;
    logic [XLEN-1:0] divisor_i;
    reg_addr_t       waddr_i;
    commit_id_t      commit_id_i;
    logic            int_i;
    logic            stall_o;
    logic            wb_ready_i;
    logic            reg_we_o;
    logic [XLEN-1:0] reg_wdata_o;
    reg_addr_t       reg_waddr_o;
    commit_id_t      commit_id_o;

    // seven words per vector, see the data file header
    logic [31:0] vec [7*MAX_VEC];
    int          n_vec = 0;
    integer      seed = 32'h31620b08;
    logic        hold_low;
    logic        stall_seen;

    // scoreboard keyed by commit id
    logic [31:0] exp_data [8];
    reg_addr_t   exp_addr [8];
    logic        pend [8];
    int          pend_count;
    commit_id_t  wr_id;

    div_unit_top #(
        .XLEN(XLEN)
    ) uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .op_i       (op_i),
        .dividend_i (dividend_i),
        .divisor_i  (divisor_i),
        .waddr_i    (waddr_i),
        .commit_id_i(commit_id_i),
        .int_i      (int_i),
        .stall_o    (stall_o),
        .wb_ready_i (wb_ready_i),
        .reg_we_o   (reg_we_o),
        .reg_wdata_o(reg_wdata_o),
        .reg_waddr_o(reg_waddr_o),
        .commit_id_o(commit_id_o)
    );

    always #50 clk = ~clk;

    task automatic end_with_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic abort_run(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %h expected %h", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    // present one vector and hold it until stall_o is low at a rising edge
    task automatic send_vector(input int idx);
        int         b;
        int         waited;
        commit_id_t id;
        b      = 7 * idx;
        waited = 0;
        @(negedge clk);
        req_i       = 1'b1;
        op_i        = div_op_e'(vec[b][1:0]);
        dividend_i  = vec[b+1];
        divisor_i   = vec[b+2];
        waddr_i     = vec[b+3][4:0];
        commit_id_i = vec[b+4][2:0];
        int_i       = vec[b+5][0];
        @(posedge clk);
        while (stall_o) begin
            waited++;
            if (waited > STALL_LIMIT) begin
                abort_run("request held by stall_o for too long");
            end
            @(posedge clk);
        end
        if (!int_i) begin
            id = commit_id_i;
            if (pend[id]) begin
                abort_run("commit id reused while its request is still in flight");
            end
            pend[id]     = 1'b1;
            exp_data[id] = vec[b+6];
            exp_addr[id] = waddr_i;
            pend_count++;
        end
    endtask

    task automatic release_request();
        @(negedge clk);
        req_i = 1'b0;
        int_i = 1'b0;
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (pend_count != 0) begin
            @(negedge clk);
            waited++;
            if (waited > STALL_LIMIT) begin
                abort_run("accepted requests were never written back");
            end
        end
        // nothing else may show up on the write port
        repeat (VEC_CYCLES) @(negedge clk);
    endtask

    // ready held low: both cores finish into full slots, buffer fills, stall rises
    task automatic run_backpressure();
        int k;
        stall_seen = 1'b0;
        @(posedge clk);
        hold_low = 1'b1;
        fork
            begin
                for (k = 0; k < BP_COUNT; k++) begin
                    send_vector(k);
                end
                release_request();
            end
            begin
                repeat (HOLD_CYCLES) @(posedge clk);
                if (!stall_seen) begin
                    abort_run("stall_o never rose while write-back was blocked");
                end
                check_value("reg_we_o", 32'(reg_we_o), 32'd1);
                hold_low = 1'b0;
            end
        join
        wait_for_drain();
    endtask

    // ready changes on the falling edge only
    always @(negedge clk) begin
        if (hold_low) begin
            wb_ready_i = 1'b0;
        end else begin
            wb_ready_i = ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (stall_o) begin
            stall_seen = 1'b1;
        end
        if (uut.u_checker.fail_count != 0) begin
            abort_run("an assertion on the DUT ports failed");
        end
        if (rst_n && reg_we_o && wb_ready_i) begin
            wr_id = commit_id_o;
            if (!pend[wr_id]) begin
                abort_run($sformatf("write to x%0d with commit id %0d has no request in flight",
                                    reg_waddr_o, wr_id));
            end
            check_value("reg_wdata_o", reg_wdata_o, exp_data[wr_id]);
            check_value("reg_waddr_o", 32'(reg_waddr_o), 32'(exp_addr[wr_id]));
            pend[wr_id] = 1'b0;
            pend_count--;
        end
    end

    initial begin
        wait (rst_n === 1'b1);
        repeat ((n_vec + BP_COUNT + 2) * VEC_CYCLES + HOLD_CYCLES + RST_CYCLES) @(posedge clk);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        int i;
        clk         = 1'b0;
        rst_n       = 1'b0;
        req_i       = 1'b0;
        op_i        = DIV;
        dividend_i  = '0;
        divisor_i   = '0;
        waddr_i     = '0;
        commit_id_i = '0;
        int_i       = 1'b0;
        wb_ready_i  = 1'b0;
        hold_low    = 1'b0;
        stall_seen  = 1'b0;
        pend_count  = 0;
        for (i = 0; i < 8; i++) begin
            pend[i] = 1'b0;
        end
        // op words are at most 3, so a larger value marks the end of the vectors
        for (i = 0; i < 7 * MAX_VEC; i++) begin
            vec[i] = 32'hF000_0000 | i;
        end
        $readmemh("testbench/div_input.txt", vec);
        while (n_vec < MAX_VEC && vec[7*n_vec] <= 32'd3) begin
            n_vec++;
        end
        if (n_vec < BP_COUNT) begin
            abort_run("too few vectors in testbench/div_input.txt");
        end

        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;

        for (i = 0; i < n_vec; i++) begin
            send_vector(i);
        end
        release_request();
        wait_for_drain();

        run_backpressure();

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- testbench/div_unit_checker.sv
`timescale 1ns/1ps

module div_unit_checker
    import div_pkg::*;
(
    input logic       clk,
    input logic       rst_n,
    input logic       req_i,
    input logic       stall_i,
    input logic       ready_i,
    input logic       we_i,
    input data_t      wdata_i,
    input reg_addr_t  waddr_i,
    input commit_id_t cid_i
);

    // read by the testbench to stop the run
    int fail_count = 0;

    // write port holds still until the register file takes it
    property port_held;
        @(posedge clk) disable iff (!rst_n)
        (we_i && !ready_i) |=>
            (we_i && $stable(wdata_i) && $stable(waddr_i) && $stable(cid_i));
    endproperty

    property no_stall_without_req;
        @(posedge clk) disable iff (!rst_n) !req_i |-> !stall_i;
    endproperty

    a_port_held: assert property (port_held) else begin
        fail_count++;
        $error("write port changed while reg_we_o waited for wb_ready_i");
    end

    a_no_stall: assert property (no_stall_without_req) else begin
        fail_count++;
        $error("stall_o high without a request");
    end

endmodule

bind div_unit_top div_unit_checker u_checker (
    .clk    (clk),
    .rst_n  (rst_n),
    .req_i  (req_i),
    .stall_i(stall_o),
    .ready_i(wb_ready_i),
    .we_i   (reg_we_o),
    .wdata_i(reg_wdata_o),
    .waddr_i(reg_waddr_o),
    .cid_i  (commit_id_o)
);

//--- hw/div_unit_top.sv
`timescale 1ns/1ps

module div_unit_top
    import div_pkg::*;
#(
    parameter int XLEN = div_pkg::XLEN
) (
    input  logic            clk,
    input  logic            rst_n,

    // request side
    input  logic            req_i,
    input  div_op_e         op_i,
    input  logic [XLEN-1:0] dividend_i,
    input  logic [XLEN-1:0] divisor_i,
    input  reg_addr_t       waddr_i,
    input  commit_id_t      commit_id_i,
    input  logic            int_i,
    output logic            stall_o,

    // write-back side
    input  logic            wb_ready_i,
    output logic            reg_we_o,
    output logic [XLEN-1:0] reg_wdata_o,
    output reg_addr_t       reg_waddr_o,
    output commit_id_t      commit_id_o
);

    div_req_t   req_data;
    div_req_t   start_req;
    logic [1:0] start;
    logic [1:0] core_idle;
    logic [1:0] core_done;
    logic [1:0] core_rel;
    div_res_t   core0_res;
    div_res_t   core1_res;

    assign req_data.op        = op_i;
    assign req_data.dividend  = dividend_i;
    assign req_data.divisor   = divisor_i;
    assign req_data.waddr     = waddr_i;
    assign req_data.commit_id = commit_id_i;

    div_issue u_issue (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .int_i      (int_i),
        .req_data_i (req_data),
        .core_idle_i(core_idle),
        .start_o    (start),
        .start_req_o(start_req),
        .stall_o    (stall_o)
    );

    // both cores see the same request, only one gets start
    div_core #(
        .XLEN(XLEN)
    ) u_core0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start[0]),
        .req_i    (start_req),
        .release_i(core_rel[0]),
        .idle_o   (core_idle[0]),
        .done_o   (core_done[0]),
        .res_o    (core0_res)
    );

    div_core #(
        .XLEN(XLEN)
    ) u_core1 (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (start[1]),
        .req_i    (start_req),
        .release_i(core_rel[1]),
        .idle_o   (core_idle[1]),
        .done_o   (core_done[1]),
        .res_o    (core1_res)
    );

    div_writeback u_writeback (
        .clk        (clk),
        .rst_n      (rst_n),
        .done_i     (core_done),
        .res0_i     (core0_res),
        .res1_i     (core1_res),
        .release_o  (core_rel),
        .wb_ready_i (wb_ready_i),
        .reg_we_o   (reg_we_o),
        .reg_wdata_o(reg_wdata_o),
        .reg_waddr_o(reg_waddr_o),
        .commit_id_o(commit_id_o)
    );

endmodule

//--- hw/div_writeback.sv
`timescale 1ns/1ps

module div_writeback
    import div_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // results from the two cores
    input  logic [1:0] done_i,
    input  div_res_t   res0_i,
    input  div_res_t   res1_i,
    output logic [1:0] release_o,

    // register write port
    input  logic       wb_ready_i,
    output logic       reg_we_o,
    output data_t      reg_wdata_o,
    output reg_addr_t  reg_waddr_o,
    output commit_id_t commit_id_o
);

    logic [1:0] slot_valid_q;
    div_res_t   slot0_q;
    div_res_t   slot1_q;
    logic       hold1_q;
    logic       sel;
    logic       fire;
    div_res_t   pick;

    // slot 0 first, unless slot 1 is already on the port and stalled
    assign sel  = hold1_q || !slot_valid_q[0];
    assign pick = sel ? slot1_q : slot0_q;

    assign reg_we_o    = |slot_valid_q;
    assign reg_wdata_o = pick.data;
    assign reg_waddr_o = pick.tag.waddr;
    assign commit_id_o = pick.tag.commit_id;

    assign fire = reg_we_o && wb_ready_i;

    // the written slot frees its core in the same cycle
    assign release_o[0] = fire && !sel;
    assign release_o[1] = fire && sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid_q <= 2'b00;
            hold1_q      <= 1'b0;
        end else begin
            // a core only finishes into an empty slot
            slot_valid_q[0] <= done_i[0] || (slot_valid_q[0] && !release_o[0]);
            slot_valid_q[1] <= done_i[1] || (slot_valid_q[1] && !release_o[1]);
            // keeps the port stable when slot 0 fills under back-pressure
            hold1_q <= reg_we_o && !wb_ready_i && sel;
        end
    end

    always_ff @(posedge clk) begin
        if (done_i[0]) begin
            slot0_q <= res0_i;
        end
        if (done_i[1]) begin
            slot1_q <= res1_i;
        end
    end

endmodule

//--- hw/div_core.sv
`timescale 1ns/1ps

module div_core
    import div_pkg::*;
#(
    parameter int XLEN = div_pkg::XLEN
) (
    input  logic     clk,
    input  logic     rst_n,

    input  logic     start_i,
    input  div_req_t req_i,
    input  logic     release_i,

    output logic     idle_o,
    output logic     done_o,
    output div_res_t res_o
);

    localparam int CNT_W = $clog2(XLEN + 1);

    core_state_e      state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             done_q;

    // payload, loaded on start and during the iterations
    div_req_t         req_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  quo_q;
    logic [XLEN-1:0]  dvs_q;
    div_res_t         res_q;

    logic             signed_op;
    logic             is_rem;
    logic             neg_dvd;
    logic             neg_dvs;
    logic             div_zero;
    logic             overflow;
    logic             last_iter;
    logic [XLEN:0]    shifted;
    logic [XLEN:0]    diff;
    logic [XLEN-1:0]  rem_nxt;
    logic [XLEN-1:0]  quo_nxt;
    logic [XLEN-1:0]  quo_fix;
    logic [XLEN-1:0]  rem_fix;
    logic [XLEN-1:0]  result;

    assign signed_op = (req_q.op == DIV) || (req_q.op == REM);
    assign is_rem    = (req_q.op == REM) || (req_q.op == REMU);
    assign neg_dvd   = signed_op && req_q.dividend[XLEN-1];
    assign neg_dvs   = signed_op && req_q.divisor[XLEN-1];

    // riscv corner cases
    assign div_zero = (req_q.divisor == '0);
    assign overflow = signed_op && (req_q.dividend == {1'b1, {(XLEN-1){1'b0}}})
                      && (&req_q.divisor);

    // cnt 0 is setup, 1..XLEN are the shift-subtract steps
    assign last_iter = (state_q == CALC) && (cnt_q == CNT_W'(XLEN));

    // one restoring step, next dividend bit shifted in from the quotient
    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dvs_q};

    always_comb begin
        if (diff[XLEN]) begin
            rem_nxt = shifted[XLEN-1:0];
            quo_nxt = {quo_q[XLEN-2:0], 1'b0};
        end else begin
            rem_nxt = diff[XLEN-1:0];
            quo_nxt = {quo_q[XLEN-2:0], 1'b1};
        end
    end

    // quotient negative on differing signs, remainder follows the dividend
    assign quo_fix = (neg_dvd ^ neg_dvs) ? -quo_nxt : quo_nxt;
    assign rem_fix = neg_dvd ? -rem_nxt : rem_nxt;

    always_comb begin
        if (div_zero) begin
            result = is_rem ? req_q.dividend : {XLEN{1'b1}};
        end else if (overflow) begin
            result = is_rem ? {XLEN{1'b0}} : req_q.dividend;
        end else begin
            result = is_rem ? rem_fix : quo_fix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= CALC;
                        cnt_q   <= '0;
                    end
                end
                CALC: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (last_iter) begin
                        state_q <= DONE;
                        done_q  <= 1'b1;
                    end
                end
                // wait until write-back has taken the result
                DONE: begin
                    if (release_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == IDLE && start_i) begin
            req_q <= req_i;
        end
        if (state_q == CALC) begin
            if (cnt_q == '0) begin
                // setup with magnitudes of the operands
                rem_q <= '0;
                quo_q <= neg_dvd ? -req_q.dividend : req_q.dividend;
                dvs_q <= neg_dvs ? -req_q.divisor : req_q.divisor;
            end else begin
                rem_q <= rem_nxt;
                quo_q <= quo_nxt;
            end
        end
        if (last_iter) begin
            res_q.tag.waddr     <= req_q.waddr;
            res_q.tag.commit_id <= req_q.commit_id;
            res_q.data          <= result;
        end
    end

    assign idle_o = (state_q == IDLE);
    assign done_o = done_q;
    assign res_o  = res_q;

endmodule

//--- hw/div_issue.sv
`timescale 1ns/1ps

module div_issue
    import div_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // request side
    input  logic       req_i,
    input  logic       int_i,
    input  div_req_t   req_data_i,

    // divider cores
    input  logic [1:0] core_idle_i,
    output logic [1:0] start_o,
    output div_req_t   start_req_o,

    output logic       stall_o
);

    logic     accept;
    logic     has_req;
    logic     any_idle;
    logic     capture;
    logic     buf_valid_q;
    div_req_t buf_q;

    // an interrupt suppresses the incoming request
    assign accept   = req_i && !int_i;
    assign any_idle = |core_idle_i;

    // the buffered request is older, so it goes first
    assign has_req     = buf_valid_q || accept;
    assign start_req_o = buf_valid_q ? buf_q : req_data_i;

    // lowest idle core wins
    assign start_o[0] = has_req && core_idle_i[0];
    assign start_o[1] = has_req && !core_idle_i[0] && core_idle_i[1];

    // new request with no free core and an empty buffer
    assign capture = accept && !buf_valid_q && !any_idle;

    // requester must hold while the buffer is occupied
    assign stall_o = buf_valid_q && accept;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid_q <= 1'b0;
        end else if (buf_valid_q) begin
            // buffer drains into whichever core started this cycle
            if (any_idle) begin
                buf_valid_q <= 1'b0;
            end
        end else if (capture) begin
            buf_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buf_q <= req_data_i;
        end
    end

endmodule

//--- hw/div_pkg.sv
package div_pkg;

    // datapath width, default for the top level
    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] data_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [2:0]      commit_id_t;

    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_op_e;

    // one division request as seen by issue and the cores
    typedef struct packed {
        div_op_e    op;
        data_t      dividend;
        data_t      divisor;
        reg_addr_t  waddr;
        commit_id_t commit_id;
    } div_req_t;

    // write-back destination of a request
    typedef struct packed {
        reg_addr_t  waddr;
        commit_id_t commit_id;
    } div_tag_t;

    typedef struct packed {
        div_tag_t tag;
        data_t    data;
    } div_res_t;

    typedef enum logic [1:0] {
        IDLE,
        CALC,
        DONE
    } core_state_e;

endpackage
